//--- source/mips_id_config.svh
`ifndef MIPS_ID_CONFIG_SVH
`define MIPS_ID_CONFIG_SVH

// data and address width
`define MIPS_XLEN 32

// register file geometry
`define MIPS_NREGS 32
`define MIPS_RAW 5

// jal, jalr, bltzal and bgezal write here
`define MIPS_LINK_REG 31

`endif

//--- source/mips_id_pkg.sv
`include "mips_id_config.svh"

package mips_id_pkg;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [`MIPS_RAW-1:0] rs;
        logic [`MIPS_RAW-1:0] rt;
        logic [`MIPS_RAW-1:0] rd;
        logic [4:0]           sa;
        logic [5:0]           func;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]           opcode;
        logic [`MIPS_RAW-1:0] rs;
        logic [`MIPS_RAW-1:0] rt;
        logic [15:0]          imm;
    } i_fields_t;

    // one instruction word, read as R or I format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    typedef struct packed {
        logic                  valid;
        logic [`MIPS_XLEN-1:0] pc;
    } fetch_t;

    typedef struct packed {
        logic id;
        logic ex;
    } stall_t;

    // forwarding or writeback strobe
    typedef struct packed {
        logic                  we;
        logic [`MIPS_RAW-1:0]  waddr;
        logic [`MIPS_XLEN-1:0] wdata;
    } rf_write_t;

    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic band;
        logic bnor;
        logic bor;
        logic bxor;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
    } alu_op_t;

    typedef struct packed {
        logic lb;
        logic lbu;
        logic lh;
        logic lhu;
        logic lw;
        logic sb;
        logic sh;
        logic sw;
    } mem_op_t;

    typedef struct packed {
        alu_op_t              alu_op;
        // [0] rs, [1] pc, [2] sa
        logic [2:0]           src1_sel;
        // [0] rt, [1] sign-ext imm, [2] const 8, [3] zero-ext imm
        logic [3:0]           src2_sel;
        mem_op_t              mem_op;
        logic                 mem_en;
        logic                 mem_wen;
        logic                 rf_we;
        logic [`MIPS_RAW-1:0] rf_waddr;
        logic                 rf_from_load;
    } ctrl_t;

    typedef struct packed {
        logic                  taken;
        logic [`MIPS_XLEN-1:0] target;
    } branch_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`MIPS_XLEN-1:0] pc;
        logic [`MIPS_XLEN-1:0] inst;
        logic [`MIPS_XLEN-1:0] rdata1;
        logic [`MIPS_XLEN-1:0] rdata2;
    } id_to_ex_t;

endpackage

//--- source/id_fetch_latch.sv
`timescale 1ns/1ps
`include "mips_id_config.svh"

module id_fetch_latch (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  mips_id_pkg::stall_t   stall_i,
    input  mips_id_pkg::fetch_t   fetch_i,
    input  logic [`MIPS_XLEN-1:0] inst_rdata_i,
    output mips_id_pkg::fetch_t   fetch_o,
    output mips_id_pkg::inst_u    inst_o
);

    mips_id_pkg::fetch_t   fetch_q;
    logic                  buf_valid;
    logic [`MIPS_XLEN-1:0] buf_inst;
    logic [`MIPS_XLEN-1:0] word;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_q   <= '0;
            buf_valid <= 1'b0;
        end else if (flush_i) begin
            fetch_q <= '0;
        end else if (stall_i.id && !stall_i.ex) begin
            // execute moves on, so hand it a bubble
            fetch_q   <= '0;
            buf_valid <= 1'b0;
        end else if (!stall_i.id) begin
            fetch_q   <= fetch_i;
            buf_valid <= 1'b0;
        end else if (!buf_valid) begin
            buf_valid <= 1'b1;
        end
    end

    // sram output moves on during a double stall, keep the first word
    always_ff @(posedge clk) begin
        if (!rst && !flush_i && stall_i.id && stall_i.ex && !buf_valid) begin
            buf_inst <= inst_rdata_i;
        end
    end

    assign word = buf_valid     ? buf_inst :
                  fetch_q.valid ? inst_rdata_i :
                                  '0;

    assign fetch_o = fetch_q;
    assign inst_o  = word;

    a_buf_needs_double_stall: assert property (
        @(posedge clk) disable iff (rst)
        $rose(buf_valid) |-> $past(stall_i.id && stall_i.ex)
    );

endmodule

//--- source/id_regfile.sv
`timescale 1ns/1ps
`include "mips_id_config.svh"

module id_regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`MIPS_RAW-1:0]     raddr1_i,
    input  logic [`MIPS_RAW-1:0]     raddr2_i,
    input  mips_id_pkg::rf_write_t   ex_fwd_i,
    input  mips_id_pkg::rf_write_t   mem_fwd_i,
    input  mips_id_pkg::rf_write_t   wb_fwd_i,
    output logic [`MIPS_XLEN-1:0]    rdata1_o,
    output logic [`MIPS_XLEN-1:0]    rdata2_o
);

    // r0 is not stored
    logic [`MIPS_XLEN-1:0] regs [1:`MIPS_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 1; k < `MIPS_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wb_fwd_i.we && wb_fwd_i.waddr != '0) begin
            regs[wb_fwd_i.waddr] <= wb_fwd_i.wdata;
        end
    end

    // youngest producer wins
    function automatic logic [`MIPS_XLEN-1:0] read_port(
        input logic [`MIPS_RAW-1:0]   addr,
        input mips_id_pkg::rf_write_t ex,
        input mips_id_pkg::rf_write_t mem,
        input mips_id_pkg::rf_write_t wb,
        input logic [`MIPS_XLEN-1:0]  stored
    );
        if (ex.we && ex.waddr == addr) begin
            return ex.wdata;
        end else if (mem.we && mem.waddr == addr) begin
            return mem.wdata;
        end else if (wb.we && wb.waddr == addr) begin
            return wb.wdata;
        end
        return stored;
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i, ex_fwd_i, mem_fwd_i, wb_fwd_i,
                             (raddr1_i == '0) ? '0 : regs[raddr1_i]);
        rdata2_o = read_port(raddr2_i, ex_fwd_i, mem_fwd_i, wb_fwd_i,
                             (raddr2_i == '0) ? '0 : regs[raddr2_i]);
    end

endmodule

//--- source/id_decoder.sv
`timescale 1ns/1ps
`include "mips_id_config.svh"

module id_decoder (
    input  logic                  valid_i,
    input  mips_id_pkg::inst_u    inst_i,
    output logic [`MIPS_RAW-1:0]  raddr1_o,
    output logic [`MIPS_RAW-1:0]  raddr2_o,
    output mips_id_pkg::ctrl_t    ctrl_o,
    output logic                  stall_load_o
);

    logic [5:0] op;
    logic [5:0] func;
    logic       special;
    logic       regimm;
    logic       sa_zero;
    logic       rs_zero;
    logic       inst_add, inst_addu, inst_sub, inst_subu;
    logic       inst_slt, inst_sltu, inst_and, inst_nor;
    logic       inst_or, inst_xor, inst_sllv, inst_srlv, inst_srav;
    logic       inst_sll, inst_srl, inst_sra;
    logic       inst_addi, inst_addiu, inst_slti, inst_sltiu;
    logic       inst_andi, inst_ori, inst_xori, inst_lui;
    logic       inst_lb, inst_lbu, inst_lh, inst_lhu, inst_lw;
    logic       inst_sb, inst_sh, inst_sw;
    logic       inst_jal, inst_jalr, inst_bltzal, inst_bgezal;
    logic       r_alu;
    logic       shift_sa;
    logic       imm_s;
    logic       imm_z;
    logic       is_load;
    logic       is_store;
    logic       is_link;

    assign op      = inst_i.r.opcode;
    assign func    = inst_i.r.func;
    assign special = valid_i && op == 6'b00_0000;
    assign regimm  = valid_i && op == 6'b00_0001;
    assign sa_zero = inst_i.r.sa == '0;
    assign rs_zero = inst_i.r.rs == '0;

    // register-register, sa must be zero
    assign inst_add  = special && sa_zero && func == 6'b10_0000;
    assign inst_addu = special && sa_zero && func == 6'b10_0001;
    assign inst_sub  = special && sa_zero && func == 6'b10_0010;
    assign inst_subu = special && sa_zero && func == 6'b10_0011;
    assign inst_and  = special && sa_zero && func == 6'b10_0100;
    assign inst_or   = special && sa_zero && func == 6'b10_0101;
    assign inst_xor  = special && sa_zero && func == 6'b10_0110;
    assign inst_nor  = special && sa_zero && func == 6'b10_0111;
    assign inst_slt  = special && sa_zero && func == 6'b10_1010;
    assign inst_sltu = special && sa_zero && func == 6'b10_1011;
    assign inst_sllv = special && sa_zero && func == 6'b00_0100;
    assign inst_srlv = special && sa_zero && func == 6'b00_0110;
    assign inst_srav = special && sa_zero && func == 6'b00_0111;

    // shift by sa, rs must be zero
    assign inst_sll = special && rs_zero && func == 6'b00_0000;
    assign inst_srl = special && rs_zero && func == 6'b00_0010;
    assign inst_sra = special && rs_zero && func == 6'b00_0011;

    assign inst_addi  = valid_i && op == 6'b00_1000;
    assign inst_addiu = valid_i && op == 6'b00_1001;
    assign inst_slti  = valid_i && op == 6'b00_1010;
    assign inst_sltiu = valid_i && op == 6'b00_1011;
    assign inst_andi  = valid_i && op == 6'b00_1100;
    assign inst_ori   = valid_i && op == 6'b00_1101;
    assign inst_xori  = valid_i && op == 6'b00_1110;
    assign inst_lui   = valid_i && op == 6'b00_1111;

    assign inst_lb  = valid_i && op == 6'b10_0000;
    assign inst_lh  = valid_i && op == 6'b10_0001;
    assign inst_lw  = valid_i && op == 6'b10_0011;
    assign inst_lbu = valid_i && op == 6'b10_0100;
    assign inst_lhu = valid_i && op == 6'b10_0101;
    assign inst_sb  = valid_i && op == 6'b10_1000;
    assign inst_sh  = valid_i && op == 6'b10_1001;
    assign inst_sw  = valid_i && op == 6'b10_1011;

    // linking jumps and branches, the rest is in the branch unit
    assign inst_jal    = valid_i && op == 6'b00_0011;
    assign inst_jalr   = special && inst_i.r.rt == '0 && sa_zero && func == 6'b00_1001;
    assign inst_bltzal = regimm && inst_i.r.rt == 5'b1_0000;
    assign inst_bgezal = regimm && inst_i.r.rt == 5'b1_0001;

    assign r_alu    = inst_add | inst_addu | inst_sub | inst_subu | inst_slt | inst_sltu
                    | inst_and | inst_nor | inst_or | inst_xor
                    | inst_sllv | inst_srlv | inst_srav;
    assign shift_sa = inst_sll | inst_srl | inst_sra;
    assign imm_s    = inst_addi | inst_addiu | inst_slti | inst_sltiu;
    assign imm_z    = inst_andi | inst_ori | inst_xori;
    assign is_load  = inst_lb | inst_lbu | inst_lh | inst_lhu | inst_lw;
    assign is_store = inst_sb | inst_sh | inst_sw;
    assign is_link  = inst_jal | inst_jalr | inst_bltzal | inst_bgezal;

    assign raddr1_o = inst_i.r.rs;
    assign raddr2_o = inst_i.r.rt;

    always_comb begin
        ctrl_o = '0;

        // link writes pc + 8 through the adder
        ctrl_o.alu_op.add  = inst_add | inst_addu | inst_addi | inst_addiu
                           | is_load | is_store | is_link;
        ctrl_o.alu_op.sub  = inst_sub | inst_subu;
        ctrl_o.alu_op.slt  = inst_slt | inst_slti;
        ctrl_o.alu_op.sltu = inst_sltu | inst_sltiu;
        ctrl_o.alu_op.band = inst_and | inst_andi;
        ctrl_o.alu_op.bnor = inst_nor;
        ctrl_o.alu_op.bor  = inst_or | inst_ori;
        ctrl_o.alu_op.bxor = inst_xor | inst_xori;
        ctrl_o.alu_op.sll  = inst_sll | inst_sllv;
        ctrl_o.alu_op.srl  = inst_srl | inst_srlv;
        ctrl_o.alu_op.sra  = inst_sra | inst_srav;
        ctrl_o.alu_op.lui  = inst_lui;

        ctrl_o.src1_sel = {shift_sa, is_link, r_alu | imm_s | imm_z | is_load | is_store};
        ctrl_o.src2_sel = {imm_z, is_link, inst_lui | imm_s | is_load | is_store,
                           r_alu | shift_sa};

        ctrl_o.mem_op = {inst_lb, inst_lbu, inst_lh, inst_lhu,
                         inst_lw, inst_sb, inst_sh, inst_sw};
        ctrl_o.mem_en       = is_load | is_store;
        ctrl_o.mem_wen      = is_store;
        ctrl_o.rf_from_load = is_load;

        ctrl_o.rf_we = r_alu | shift_sa | imm_s | imm_z | inst_lui | is_load | is_link;
        if (r_alu || shift_sa) begin
            ctrl_o.rf_waddr = inst_i.r.rd;
        end else if (imm_s || imm_z || inst_lui || is_load) begin
            ctrl_o.rf_waddr = inst_i.i.rt;
        end else if (is_link) begin
            ctrl_o.rf_waddr = `MIPS_RAW'(`MIPS_LINK_REG);
        end
    end

    assign stall_load_o = is_load;

    always_comb begin
        a_alu_onehot: assert ($onehot0(ctrl_o.alu_op));
    end

endmodule

//--- source/id_branch_unit.sv
`timescale 1ns/1ps
`include "mips_id_config.svh"

module id_branch_unit (
    input  logic                  valid_i,
    input  logic [`MIPS_XLEN-1:0] pc_i,
    input  mips_id_pkg::inst_u    inst_i,
    input  logic [`MIPS_XLEN-1:0] rdata1_i,
    input  logic [`MIPS_XLEN-1:0] rdata2_i,
    output mips_id_pkg::branch_t  br_o
);

    logic [5:0]            op;
    logic [`MIPS_RAW-1:0]  rt;
    logic                  special;
    logic                  regimm;
    logic                  b_eq, b_ne, b_gez, b_gtz, b_lez, b_ltz, b_ltzal, b_gezal;
    logic                  j_abs, j_reg;
    logic                  cond_br;
    logic                  rs_zero;
    logic                  rs_neg;
    logic [`MIPS_XLEN-1:0] pc_plus_4;
    logic [`MIPS_XLEN-1:0] br_target;
    logic [`MIPS_XLEN-1:0] j_target;

    assign op      = inst_i.i.opcode;
    assign rt      = inst_i.i.rt;
    assign special = valid_i && op == 6'b00_0000;
    assign regimm  = valid_i && op == 6'b00_0001;

    assign b_eq    = valid_i && op == 6'b00_0100;
    assign b_ne    = valid_i && op == 6'b00_0101;
    assign b_lez   = valid_i && op == 6'b00_0110 && rt == '0;
    assign b_gtz   = valid_i && op == 6'b00_0111 && rt == '0;
    assign b_ltz   = regimm && rt == 5'b0_0000;
    assign b_gez   = regimm && rt == 5'b0_0001;
    assign b_ltzal = regimm && rt == 5'b1_0000;
    assign b_gezal = regimm && rt == 5'b1_0001;

    // j and jal
    assign j_abs = valid_i && op[5:1] == 5'b0_0001;
    // jr needs rd zero, jalr does not
    assign j_reg = special && rt == '0 && inst_i.r.sa == '0
                && ((inst_i.r.func == 6'b00_1000 && inst_i.r.rd == '0)
                ||  inst_i.r.func == 6'b00_1001);

    assign cond_br = b_eq | b_ne | b_gez | b_gtz | b_lez | b_ltz | b_ltzal | b_gezal;

    assign rs_zero = rdata1_i == '0;
    assign rs_neg  = rdata1_i[`MIPS_XLEN-1];

    assign pc_plus_4 = pc_i + `MIPS_XLEN'd4;
    assign br_target = pc_plus_4
                     + {{(`MIPS_XLEN-18){inst_i.i.imm[15]}}, inst_i.i.imm, 2'b00};
    assign j_target  = {pc_i[`MIPS_XLEN-1:28], inst_i.i.rs, inst_i.i.rt, inst_i.i.imm, 2'b00};

    always_comb begin
        br_o.taken = (b_eq && rdata1_i == rdata2_i)
                   | (b_ne && rdata1_i != rdata2_i)
                   | ((b_gez || b_gezal) && !rs_neg)
                   | (b_gtz && !rs_neg && !rs_zero)
                   | (b_lez && (rs_neg || rs_zero))
                   | ((b_ltz || b_ltzal) && rs_neg)
                   | j_abs | j_reg;

        if (cond_br) begin
            br_o.target = br_target;
        end else if (j_abs) begin
            br_o.target = j_target;
        end else if (j_reg) begin
            br_o.target = rdata1_i;
        end else begin
            br_o.target = '0;
        end
    end

endmodule

//--- source/id_stage.sv
`timescale 1ns/1ps
`include "mips_id_config.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  mips_id_pkg::stall_t    stall_i,
    input  mips_id_pkg::fetch_t    fetch_i,
    input  logic [`MIPS_XLEN-1:0]  inst_rdata_i,
    input  mips_id_pkg::rf_write_t ex_fwd_i,
    input  mips_id_pkg::rf_write_t mem_fwd_i,
    input  mips_id_pkg::rf_write_t wb_fwd_i,
    output mips_id_pkg::id_to_ex_t id_to_ex_o,
    output mips_id_pkg::branch_t   br_o,
    output logic                   stall_load_o
);

    mips_id_pkg::fetch_t   fetch_q;
    mips_id_pkg::inst_u    inst;
    mips_id_pkg::ctrl_t    ctrl;
    logic [`MIPS_RAW-1:0]  raddr1;
    logic [`MIPS_RAW-1:0]  raddr2;
    logic [`MIPS_XLEN-1:0] rdata1;
    logic [`MIPS_XLEN-1:0] rdata2;

    id_fetch_latch u_fetch_latch (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .fetch_i      (fetch_i),
        .inst_rdata_i (inst_rdata_i),
        .fetch_o      (fetch_q),
        .inst_o       (inst)
    );

    id_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .raddr1_i  (raddr1),
        .raddr2_i  (raddr2),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .rdata1_o  (rdata1),
        .rdata2_o  (rdata2)
    );

    id_decoder u_decoder (
        .valid_i      (fetch_q.valid),
        .inst_i       (inst),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .ctrl_o       (ctrl),
        .stall_load_o (stall_load_o)
    );

    id_branch_unit u_branch_unit (
        .valid_i  (fetch_q.valid),
        .pc_i     (fetch_q.pc),
        .inst_i   (inst),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .br_o     (br_o)
    );

    always_comb begin
        id_to_ex_o.ctrl   = ctrl;
        id_to_ex_o.pc     = fetch_q.pc;
        id_to_ex_o.inst   = inst;
        id_to_ex_o.rdata1 = rdata1;
        id_to_ex_o.rdata2 = rdata2;
    end

endmodule

//--- sim/id_stage_tb.sv
`timescale 1ns/1ps
`include "mips_id_config.svh"

module id_stage_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam string DATA_FILE = "sim/id_testdata.txt";

    typedef struct packed {
        logic                  flush;
        logic [1:0]            stall;
        logic                  valid;
        logic [`MIPS_XLEN-1:0] pc;
        logic [`MIPS_XLEN-1:0] inst;
        logic [5:0]            ex_code;
        logic [`MIPS_XLEN-1:0] ex_data;
        logic [5:0]            mem_code;
        logic [`MIPS_XLEN-1:0] mem_data;
        logic [5:0]            wb_code;
        logic [`MIPS_XLEN-1:0] wb_data;
        logic [63:0]           e1;
        logic [31:0]           e2;
        logic [31:0]           e3;
    } record_t;

    logic                   clk;
    logic                   rst;
    logic                   flush_i;
    mips_id_pkg::stall_t    stall_i;
    mips_id_pkg::fetch_t    fetch_i;
    logic [`MIPS_XLEN-1:0]  inst_rdata_i;
    mips_id_pkg::rf_write_t ex_fwd_i;
    mips_id_pkg::rf_write_t mem_fwd_i;
    mips_id_pkg::rf_write_t wb_fwd_i;
    mips_id_pkg::id_to_ex_t id_to_ex_o;
    mips_id_pkg::branch_t   br_o;
    logic                   stall_load_o;

    record_t recs[$];
    string   rec_kind[$];
    string   rec_name[$];
    int      errors;
    int      checks;
    logic    loaded;

    id_stage uut (
        .clk          (clk),
        .rst          (rst),
        .flush_i      (flush_i),
        .stall_i      (stall_i),
        .fetch_i      (fetch_i),
        .inst_rdata_i (inst_rdata_i),
        .ex_fwd_i     (ex_fwd_i),
        .mem_fwd_i    (mem_fwd_i),
        .wb_fwd_i     (wb_fwd_i),
        .id_to_ex_o   (id_to_ex_o),
        .br_o         (br_o),
        .stall_load_o (stall_load_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // idle strobes carry random data so stale wdata cannot leak through
    function automatic mips_id_pkg::rf_write_t make_strobe(input logic [5:0] code,
                                                           input logic [31:0] data);
        mips_id_pkg::rf_write_t s;
        s.we    = code[5];
        s.waddr = code[4:0];
        s.wdata = code[5] ? data : $urandom();
        return s;
    endfunction

    task automatic load_records();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [63:0] fl, st, vl, pc, inst, exc, exd, mc, md, wc, wd, e1, e2, e3;
        record_t     r;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the data file %s", DATA_FILE);
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            kind, name, fl, st, vl, pc, inst, exc, exd, mc, md, wc, wd,
                            e1, e2, e3);
                if (n == 16) begin
                    r.flush    = fl[0];
                    r.stall    = st[1:0];
                    r.valid    = vl[0];
                    r.pc       = pc[31:0];
                    r.inst     = inst[31:0];
                    r.ex_code  = exc[5:0];
                    r.ex_data  = exd[31:0];
                    r.mem_code = mc[5:0];
                    r.mem_data = md[31:0];
                    r.wb_code  = wc[5:0];
                    r.wb_data  = wd[31:0];
                    r.e1       = e1;
                    r.e2       = e2[31:0];
                    r.e3       = e3[31:0];
                    recs.push_back(r);
                    rec_kind.push_back(kind);
                    rec_name.push_back(name);
                end else begin
                    errors++;
                    $display("malformed line in the data file: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_record(input record_t r);
        flush_i      = r.flush;
        stall_i      = r.stall;
        fetch_i      = {r.valid, r.pc};
        inst_rdata_i = r.inst;
        ex_fwd_i     = make_strobe(r.ex_code, r.ex_data);
        mem_fwd_i    = make_strobe(r.mem_code, r.mem_data);
        wb_fwd_i     = make_strobe(r.wb_code, r.wb_data);
    endtask

    task automatic check_record(input string kind, input string name, input record_t r);
        case (kind)
            "S": begin
                check({name, ".pc"}, r.e1, id_to_ex_o.pc);
                check({name, ".inst"}, r.e2, id_to_ex_o.inst);
                check({name, ".we_taken"}, r.e3, {id_to_ex_o.ctrl.rf_we, br_o.taken});
            end
            "R": begin
                check({name, ".rdata1"}, r.e1, id_to_ex_o.rdata1);
                check({name, ".rdata2"}, r.e2, id_to_ex_o.rdata2);
            end
            "D": begin
                check({name, ".ctrl"}, r.e1, id_to_ex_o.ctrl);
                check({name, ".stall_load"}, r.e2, stall_load_o);
            end
            "B": begin
                check({name, ".taken"}, r.e1, br_o.taken);
                check({name, ".target"}, r.e2, br_o.target);
            end
            default: begin
                errors++;
                $display("record %s has an unknown kind %s", name, kind);
            end
        endcase
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        flush_i      = 1'b0;
        stall_i      = '0;
        fetch_i      = '0;
        inst_rdata_i = '0;
        ex_fwd_i     = '0;
        mem_fwd_i    = '0;
        wb_fwd_i     = '0;
        errors       = 0;
        checks       = 0;
        loaded       = 1'b0;
        void'($urandom(80));
        load_records();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < recs.size(); i++) begin
            drive_record(recs[i]);
            @(posedge clk);
            @(negedge clk);
            check_record(rec_kind[i], rec_name[i], recs[i]);
        end
        $display("errors: %0d, checks: %0d, records: %0d", errors, checks, recs.size());
        if (errors == 0 && checks > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // four cycles per record is far more than the one each needs
    initial begin
        longint limit_ns;
        wait (loaded);
        limit_ns = longint'(recs.size()) * 4 * CLK_PERIOD + (RESET_CYCLES + 2) * CLK_PERIOD;
        #(limit_ns * 1ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sim/id_testdata.txt
# kind name flush stall(id,ex) valid pc inst ex{we,addr} ex_data mem{we,addr} mem_data wb{we,addr} wb_data e1 e2 e3
# kinds: S pc inst {rf_we,taken} | R rdata1 rdata2 - | D ctrl stall_load - | B taken target -
S idle 0 0 0 00000000 00221820 00 00000000 00 00000000 00 00000000 00000000 00000000 0
R wb_r5 0 0 1 00400000 00a51820 00 00000000 00 00000000 25 deadbeef deadbeef deadbeef 0
R array_r5 0 0 1 00400004 00a51820 00 00000000 00 00000000 00 00000000 deadbeef deadbeef 0
R zero_r0 0 0 1 00400008 00001820 00 00000000 00 00000000 00 00000000 00000000 00000000 0
R byp_ex 0 0 1 0040000c 00c61820 26 11111111 26 22222222 26 33333333 11111111 11111111 0
R byp_mem 0 0 1 0040000c 00c61820 00 00000000 26 22222222 26 33333333 22222222 22222222 0
R byp_wb 0 0 1 0040000c 00c61820 00 00000000 00 00000000 26 33333333 33333333 33333333 0
D add 0 0 1 00400100 00221820 00 00000000 00 00000000 00 00000000 800220046 0 0
D addiu 0 0 1 00400100 24240010 00 00000000 00 00000000 00 00000000 800240048 0 0
D ori 0 0 1 00400100 342500ff 00 00000000 00 00000000 00 00000000 02030004a 0 0
D lui 0 0 1 00400100 3c061234 00 00000000 00 00000000 00 00000000 00104004c 0 0
D sll 0 0 1 00400100 000238c0 00 00000000 00 00000000 00 00000000 00882004e 0 0
D srav 0 0 1 00400100 00224007 00 00000000 00 00000000 00 00000000 002220050 0 0
D slt 0 0 1 00400100 0022482a 00 00000000 00 00000000 00 00000000 200220052 0 0
D lw 0 0 1 00400100 8c2a0008 00 00000000 00 00000000 00 00000000 800241155 1 0
D lb 0 0 1 00400100 804bfffc 00 00000000 00 00000000 00 00000000 800250157 1 0
D sh 0 0 1 00400100 a4230002 00 00000000 00 00000000 00 00000000 800240580 0 0
D sw 0 0 1 00400100 ac220000 00 00000000 00 00000000 00 00000000 800240380 0 0
D jal 0 0 1 00400100 0c000100 00 00000000 00 00000000 00 00000000 80048007e 0 0
B beq 0 0 1 00400000 10220004 21 00000005 22 00000005 00 00000000 1 00400014 0
B bne_taken 0 0 1 00400000 14220004 21 00000005 22 00000006 00 00000000 1 00400014 0
B bne_not 0 0 1 00400000 14220004 21 00000005 22 00000005 00 00000000 0 00400014 0
B bgez 0 0 1 00400000 0421ffff 21 00000000 00 00000000 00 00000000 1 00400000 0
B bgtz 0 0 1 00400000 1c200008 21 00000000 00 00000000 00 00000000 0 00400024 0
B blez 0 0 1 00400000 18200008 21 00000000 00 00000000 00 00000000 1 00400024 0
B bltz 0 0 1 00400000 04200008 21 80000000 00 00000000 00 00000000 1 00400024 0
B j 0 0 1 10000010 08000100 00 00000000 00 00000000 00 00000000 1 10000400 0
B jr 0 0 1 00400000 00200008 21 00401000 00 00000000 00 00000000 1 00401000 0
B jalr 0 0 1 00400000 0020f809 21 00402000 00 00000000 00 00000000 1 00402000 0
S capture 0 0 1 00400100 0c000100 00 00000000 00 00000000 00 00000000 00400100 0c000100 3
S flush 1 0 1 00400104 0c000100 00 00000000 00 00000000 00 00000000 00000000 00000000 0
S recapture 0 0 1 00400108 00221820 00 00000000 00 00000000 00 00000000 00400108 00221820 2
S id_stall 0 2 1 0040010c 00221820 00 00000000 00 00000000 00 00000000 00000000 00000000 0
S refill 0 0 1 0040010c 0c000100 00 00000000 00 00000000 00 00000000 0040010c 0c000100 3
S dbl_first 0 3 1 00400110 0c000100 00 00000000 00 00000000 00 00000000 0040010c 0c000100 3
S dbl_hold 0 3 1 00400110 00221820 00 00000000 00 00000000 00 00000000 0040010c 0c000100 3
S release 0 0 1 00400110 00221820 00 00000000 00 00000000 00 00000000 00400110 00221820 2

//--- flist.f
+incdir+source
source/mips_id_pkg.sv
source/id_fetch_latch.sv
source/id_regfile.sv
source/id_decoder.sv
source/id_branch_unit.sv
source/id_stage.sv
sim/id_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= id_stage_tb
RTL_TOP   ?= id_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TOP)
	@out="$$(./$(OBJ_DIR)/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
